// File: Makefile
SRCS := $(wildcard hdl/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/Vuart_tx_tb
	@out=$$(./obj_dir/Vuart_tx_tb); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

obj_dir/Vuart_tx_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module uart_tx_tb -f files.f -o Vuart_tx_tb

clean:
	rm -rf obj_dir

// File: files.f
hdl/uart_pkg.sv
hdl/tx_fifo.sv
hdl/apb_regs.sv
hdl/baud_timer.sv
hdl/tx_sequencer.sv
hdl/uart_tx_top.sv
test/uart_tx_properties.sv
test/uart_tx_tb.sv

// File: hdl/apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module apb_regs #(
  parameter int div_bits = 16,
  parameter int abits    = 4
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [3:0]                     paddr,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  input  logic                           full,
  input  logic                           empty,
  input  logic                           busy,
  output logic                           push,
  output logic [uart_pkg::data_bits-1:0] push_data,
  output logic                           enable,
  output logic [div_bits-1:0]            divisor
);

  import uart_pkg::*;

  localparam logic [div_bits-1:0] div_reset = div_bits'(16);

  // divisor must fit the 16-bit config field, fifo needs at least two entries
  if (div_bits > 16 || div_bits < 2 || abits < 1)
  begin : g_param_check
    $error("apb_regs: unsupported div_bits or abits");
  end

  reg_word_u   wr_word;     // pwdata seen through the register views
  reg_word_u   cfg_word;    // config readback
  logic [31:0] status_word;
  logic        wr_access;
  logic        rd_access;
  logic        overflow;    // sticky, set by a write while full

  assign wr_word   = pwdata;
  assign wr_access = psel & penable & pwrite;  // takes effect at the closing edge
  assign rd_access = psel & penable & ~pwrite;

  // fifo write port, dropped when full
  assign push      = wr_access && (paddr == addr_data) && !full;
  assign push_data = wr_word.tx_byte.data;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      enable   <= 1'b0;
      divisor  <= div_reset;
      overflow <= 1'b0;
    end
    else if (wr_access)
    begin
      case (paddr)
        addr_data:
          if (full)
            overflow <= 1'b1;  // byte is lost
        addr_config:
        begin
          enable  <= wr_word.cfg.enable;
          divisor <= wr_word.cfg.divisor[div_bits-1:0];
        end
        addr_status:
          if (pwdata[stat_overflow])
            overflow <= 1'b0;  // write one to clear
        default: ;
      endcase
    end
  end

  // readback words
  always_comb
  begin
    cfg_word             = '0;
    cfg_word.cfg.enable  = enable;
    cfg_word.cfg.divisor = 16'(divisor);
    status_word                = '0;
    status_word[stat_empty]    = empty;
    status_word[stat_full]     = full;
    status_word[stat_busy]     = busy;
    status_word[stat_overflow] = overflow;
  end

  // read mux, zero outside the access phase and for data
  always_comb
  begin
    prdata = '0;
    if (rd_access)
    begin
      case (paddr)
        addr_config: prdata = cfg_word;
        addr_status: prdata = status_word;
        default:     prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/baud_timer.sv
`timescale 1ns/100ps
`default_nettype none

module baud_timer #(
  parameter int div_bits = 16
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                run,      // high for a whole frame
  input  logic [div_bits-1:0] divisor,  // cycles per bit
  output logic                bit_tick
);

  logic [div_bits-1:0] count;  // cycles left in the current bit, minus one

  // last cycle of each bit period
  assign bit_tick = run && (count == '0);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      count <= '0;
    else if (!run || bit_tick)
      count <= divisor - 1'b1;  // parked at a full period while idle
    else
      count <= count - 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/tx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module tx_fifo #(
  parameter int abits     = 4,
  parameter int data_bits = uart_pkg::data_bits
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 push,       // caller guarantees not full
  input  logic                 pop,
  input  logic [data_bits-1:0] push_data,
  output logic [data_bits-1:0] pop_data,   // valid the cycle after pop
  output logic                 empty,
  output logic                 full
);

  logic [data_bits-1:0] mem [2**abits];  // 2^abits entries
  logic [abits-1:0] wr_ptr, wr_next, wr_succ;
  logic [abits-1:0] rd_ptr, rd_next, rd_succ;
  logic             full_next, empty_next;
  logic             do_pop;

  assign do_pop = pop & ~empty;  // a pop on empty is ignored

  // storage, no reset needed
  always_ff @(posedge clock)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // registered read port
  always_ff @(posedge clock)
  begin
    if (do_pop)
      pop_data <= mem[rd_ptr];
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      wr_ptr <= wr_next;
      rd_ptr <= rd_next;
      full   <= full_next;
      empty  <= empty_next;
    end
  end

  // next-state logic for pointers and flags
  always_comb
  begin
    wr_succ    = wr_ptr + 1'b1;
    rd_succ    = rd_ptr + 1'b1;
    wr_next    = wr_ptr;  // hold by default
    rd_next    = rd_ptr;
    full_next  = full;
    empty_next = empty;
    case ({push, do_pop})
      2'b01:
      begin
        rd_next   = rd_succ;
        full_next = 1'b0;
        if (rd_succ == wr_ptr)
          empty_next = 1'b1;  // last word left
      end
      2'b10, 2'b11:
      begin
        wr_next = wr_succ;
        if (do_pop)
          rd_next = rd_succ;  // both move, occupancy and flags unchanged
        else
        begin
          empty_next = 1'b0;
          if (wr_succ == rd_ptr)
            full_next = 1'b1;  // writer caught up with reader
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/tx_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module tx_sequencer (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           enable,
  input  logic                           empty,
  input  logic                           bit_tick,
  input  logic [uart_pkg::data_bits-1:0] pop_data,
  output logic                           pop,
  output logic                           run,
  output logic                           busy,
  output logic                           tx
);

  import uart_pkg::*;

  typedef enum logic [2:0] {idle, load, start, data, stop} state_t;

  state_t             state;
  logic [data_bits:0] shift;      // data byte with the stop bit on top
  logic [2:0]         bit_count;  // data bits already sent

  // fetch a byte only from idle, so pop is a single-cycle pulse
  assign pop  = (state == idle) && !empty && enable;
  assign busy = (state != idle);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state     <= idle;
      run       <= 1'b0;
      tx        <= 1'b1;  // line idles high
      bit_count <= '0;
    end
    else
    begin
      case (state)
        idle:
          if (pop)
            state <= load;
        load:
        begin
          state     <= start;  // fifo read data is valid now
          tx        <= 1'b0;   // start bit
          run       <= 1'b1;
          bit_count <= '0;
        end
        start:
          if (bit_tick)
          begin
            state <= data;
            tx    <= shift[0];  // lsb first
          end
        data:
          if (bit_tick)
          begin
            tx        <= shift[0];
            bit_count <= bit_count + 1'b1;
            if (bit_count == 3'd7)
              state <= stop;  // shift[0] holds the stop bit here
          end
        stop:
          if (bit_tick)
          begin
            state <= idle;
            run   <= 1'b0;
          end
        default:
          state <= idle;
      endcase
    end
  end

  // shift register, payload only
  always_ff @(posedge clock)
  begin
    if (state == load)
      shift <= {1'b1, pop_data};
    else if (bit_tick && (state == start || state == data))
      shift <= shift >> 1;
  end

endmodule

`default_nettype wire

// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // apb register map, byte offsets within the 4-bit address space
  localparam logic [3:0] addr_data   = 4'd0;  // write pushes one byte
  localparam logic [3:0] addr_config = 4'd4;  // enable and bit divisor
  localparam logic [3:0] addr_status = 4'd8;  // flags, overflow is write-one-to-clear

  // status word bit positions
  localparam int stat_empty    = 0;
  localparam int stat_full     = 1;
  localparam int stat_busy     = 2;
  localparam int stat_overflow = 3;

  localparam int data_bits = 8;  // bits per frame, start and stop excluded

  // data register view
  typedef struct packed {
    logic [23:0] unused;
    logic [7:0]  data;
  } tx_byte_t;

  // config register view, divisor sits in the low half
  typedef struct packed {
    logic [14:0] unused;
    logic        enable;
    logic [15:0] divisor;
  } cfg_t;

  // one bus word, read as a byte or as configuration
  typedef union packed {
    tx_byte_t tx_byte;
    cfg_t     cfg;
  } reg_word_u;

endpackage

`default_nettype wire

// File: hdl/uart_tx_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_top #(
  parameter int abits    = 4,   // fifo holds 2^abits bytes
  parameter int div_bits = 16
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        tx
);

  import uart_pkg::*;

  logic                 push, pop;
  logic [data_bits-1:0] push_data, pop_data;
  logic                 empty, full;
  logic                 enable, busy;
  logic [div_bits-1:0]  divisor;
  logic                 run, bit_tick;

  apb_regs #(
    .div_bits (div_bits),
    .abits    (abits)
  ) i_regs (
    .clock     (clock),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .full      (full),
    .empty     (empty),
    .busy      (busy),
    .push      (push),
    .push_data (push_data),
    .enable    (enable),
    .divisor   (divisor)
  );

  tx_fifo #(
    .abits     (abits),
    .data_bits (data_bits)
  ) i_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (push),
    .pop       (pop),
    .push_data (push_data),
    .pop_data  (pop_data),
    .empty     (empty),
    .full      (full)
  );

  baud_timer #(
    .div_bits (div_bits)
  ) i_timer (
    .clock    (clock),
    .reset    (reset),
    .run      (run),
    .divisor  (divisor),
    .bit_tick (bit_tick)
  );

  tx_sequencer i_seq (
    .clock    (clock),
    .reset    (reset),
    .enable   (enable),
    .empty    (empty),
    .bit_tick (bit_tick),
    .pop_data (pop_data),
    .pop      (pop),
    .run      (run),
    .busy     (busy),
    .tx       (tx)     // serial line
  );

endmodule

`default_nettype wire

// File: test/uart_tx_properties.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_properties (
  input logic clock,
  input logic reset,
  input logic tx,
  input logic busy,
  input logic push,
  input logic full,
  input logic pop
);

  // line rests high between frames
  a_idle_high: assert property (@(posedge clock) disable iff (reset) !busy |-> tx)
    else $error("tx low while sequencer idle");

  // apb_regs drops writes when full
  a_push_not_full: assert property (@(posedge clock) disable iff (reset) push |-> !full)
    else $error("fifo push while full");

  a_single_pop: assert property (@(posedge clock) disable iff (reset) pop |=> !pop)
    else $error("pop held for two cycles");

  // reset values on the line and the busy flag
  a_reset_values: assert property (@(posedge clock) reset |-> (tx && !busy))
    else $error("tx or busy wrong during reset");

endmodule

bind uart_tx_top uart_tx_properties i_props (
  .clock (clock),
  .reset (reset),
  .tx    (tx),
  .busy  (busy),
  .push  (push),
  .full  (full),
  .pop   (pop)
);

`default_nettype wire

// File: test/uart_tx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_tb;

  import uart_pkg::*;

  localparam int fifo_depth     = 16;
  localparam int max_divisor    = 16;
  localparam int timeout_cycles = 40 * 10 * max_divisor * 2;  // 40 slow frames with twofold margin

  logic        clock;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        tx;

  integer     seed = 26686;
  int         cycle_count = 0;
  int         cur_div = 16;  // divisor last written to config
  logic [7:0] exp_q[$];      // written bytes not yet seen on tx

  uart_tx_top #(
    .abits    (4),
    .div_bits (16)
  ) i_dut (
    .clock   (clock),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .tx      (tx)
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // watchdog on total run length
  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
      abort_run($sformatf("timeout after %0d cycles, no progress on tx", timeout_cycles));
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected)
      abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h",
                          $time, name, expected, actual));
  endtask

  task automatic check_word(input string name, input reg_word_u expected,
                            input reg_word_u actual);
    if (actual !== expected)
      abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h",
                          $time, name, expected, actual));
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("Fail time=%0t %s expected=%b actual=%b",
                          $time, name, expected, actual));
  endtask

  function automatic reg_word_u config_word(input logic en, input int div);
    reg_word_u w;
    w             = '0;
    w.cfg.enable  = en;
    w.cfg.divisor = 16'(div);
    return w;
  endfunction

  function automatic reg_word_u expected_status(input logic e, input logic f,
                                                input logic b, input logic o);
    logic [31:0] s;
    s                = '0;
    s[stat_empty]    = e;
    s[stat_full]     = f;
    s[stat_busy]     = b;
    s[stat_overflow] = o;
    return s;
  endfunction

  task automatic apb_write(input logic [3:0] addr, input reg_word_u word);
    @(posedge clock);
    psel    <= 1'b1;  // setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= word;
    @(posedge clock);
    penable <= 1'b1;
    @(posedge clock);  // write lands on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output reg_word_u word);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);  // prdata settled mid access phase
    word = prdata;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_config(input logic en, input int div);
    apb_write(addr_config, config_word(en, div));
    cur_div = div;
  endtask

  task automatic send_byte(input logic [7:0] b);
    reg_word_u w;
    w              = '0;
    w.tx_byte.data = b;
    apb_write(addr_data, w);
    if (exp_q.size() < fifo_depth)
      exp_q.push_back(b);  // a full fifo drops it
  endtask

  // every cycle of a bit must hold the level seen in its first cycle
  task automatic receive_frame(input int div, output logic [7:0] b);
    logic [9:0] bits;
    logic       level;
    int         waited;
    waited = 0;
    bits   = '0;
    level  = 1'b1;
    @(negedge clock);
    while (tx !== 1'b0)
    begin
      @(negedge clock);
      waited++;
      if (waited > 20 * div + 64)
        abort_run("no start bit appeared on tx");
    end
    for (int k = 0; k < 10; k++)
    begin
      for (int c = 0; c < div; c++)
      begin
        if (k != 0 || c != 0)
          @(negedge clock);
        if (c == 0)
          level = tx;
        else
          check_bit("tx", level, tx);
      end
      bits = {level, bits[9:1]};  // start ends up in bit 0
    end
    check_bit("stop bit", 1'b1, bits[9]);
    b = bits[8:1];
  endtask

  task automatic receive_expected(input int count);
    logic [7:0] got;
    logic [7:0] want;
    for (int i = 0; i < count; i++)
    begin
      receive_frame(cur_div, got);
      if (exp_q.size() == 0)
        abort_run("a byte arrived on tx that was never written");
      want = exp_q.pop_front();
      check_byte("tx byte", want, got);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge clock);
      if (tx !== 1'b1)
        abort_run("tx left idle while transmission was disabled");
    end
  endtask

  task automatic reset_values();
    reg_word_u rd;
    apb_read(addr_status, rd);
    check_word("status", expected_status(1'b1, 1'b0, 1'b0, 1'b0), rd);
    apb_read(addr_config, rd);
    check_word("config", config_word(1'b0, 16), rd);
    @(negedge clock);
    check_bit("tx", 1'b1, tx);
  endtask

  task automatic single_frame();
    set_config(1'b1, 8);
    send_byte(8'($random(seed)));
    receive_expected(1);
  endtask

  task automatic burst_order();
    reg_word_u rd;
    set_config(1'b1, 5);
    fork
      begin
        for (int i = 0; i < 10; i++)
          send_byte(8'($random(seed)));
      end
      receive_expected(10);
    join
    apb_read(addr_status, rd);
    check_word("status", expected_status(1'b1, 1'b0, 1'b0, 1'b0), rd);
  endtask

  task automatic overflow_drain();
    reg_word_u rd;
    set_config(1'b0, 4);
    for (int i = 0; i < 17; i++)
      send_byte(8'($random(seed)));  // last one overflows
    apb_read(addr_status, rd);
    check_word("status", expected_status(1'b0, 1'b1, 1'b0, 1'b1), rd);
    set_config(1'b1, 4);
    receive_expected(16);
    apb_read(addr_status, rd);
    check_word("status", expected_status(1'b1, 1'b0, 1'b0, 1'b1), rd);
    apb_write(addr_status, expected_status(1'b0, 1'b0, 1'b0, 1'b1));  // clear overflow
    apb_read(addr_status, rd);
    check_word("status", expected_status(1'b1, 1'b0, 1'b0, 1'b0), rd);
  endtask

  task automatic enable_gating();
    reg_word_u rd;
    set_config(1'b1, 6);
    send_byte(8'($random(seed)));
    fork
      receive_expected(1);
      begin
        send_byte(8'($random(seed)));
        send_byte(8'($random(seed)));
        repeat (3 * 6) @(posedge clock);  // well inside the first frame
        set_config(1'b0, 6);
      end
    join
    expect_quiet(40 * 6);
    apb_read(addr_status, rd);
    check_word("status", expected_status(1'b0, 1'b0, 1'b0, 1'b0), rd);
    set_config(1'b1, 6);
    receive_expected(2);
  endtask

  task automatic divisor_change();
    set_config(1'b1, 3);
    send_byte(8'($random(seed)));
    receive_expected(1);
    set_config(1'b1, 12);
    send_byte(8'($random(seed)));
    receive_expected(1);
  endtask

  initial
  begin
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    reset_values();
    single_frame();
    burst_order();
    overflow_drain();
    enable_gating();
    divisor_change();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
